// File: Bender.yml
package:
  name: alu_pipe

sources:
  - hdl/alu_pipe_pkg.sv
  - hdl/reg_file.sv
  - hdl/decode_stage.sv
  - hdl/hazard_control.sv
  - hdl/execute_stage.sv
  - hdl/retire_stage.sv
  - hdl/alu_pipe_top.sv
  - target: test
    files:
      - testbench/alu_pipe_props.sv
      - testbench/alu_pipe_tb.sv

// File: alu_pipe.f
hdl/alu_pipe_pkg.sv
hdl/reg_file.sv
hdl/decode_stage.sv
hdl/hazard_control.sv
hdl/execute_stage.sv
hdl/retire_stage.sv
hdl/alu_pipe_top.sv
testbench/alu_pipe_props.sv
testbench/alu_pipe_tb.sv

// File: hdl/alu_pipe_pkg.sv
`default_nettype none

package alu_pipe_pkg;

    // register file geometry
    parameter int REG_ADDR_W = 5;
    parameter int NUM_REGS = 32;

    // immediate field, sign-extended to the datapath width
    parameter int IMM_W = 16;

    // instruction opcodes
    typedef enum logic [2:0] {
        OP_NOP  = 3'd0,
        OP_ADD  = 3'd1,
        OP_SUB  = 3'd2,
        OP_AND  = 3'd3,
        OP_OR   = 3'd4,
        OP_XOR  = 3'd5,
        OP_ADDI = 3'd6,
        OP_BEQ  = 3'd7
    } opcode_e;

    // operand source in execute
    typedef enum logic [1:0] {
        FWD_NONE = 2'd0,
        FWD_MEM  = 2'd1,
        FWD_WB   = 2'd2
    } fwd_sel_e;

    // 34-bit instruction word as it arrives on in_instr
    typedef struct packed {
        opcode_e                 opcode;
        logic [REG_ADDR_W-1:0]   rd;
        logic [REG_ADDR_W-1:0]   rs1;
        logic [REG_ADDR_W-1:0]   rs2;
        logic [IMM_W-1:0]        imm;
    } instr_t;

    // payload of the memory-position and writeback stages
    typedef struct packed {
        logic                    valid;
        logic                    wr;
        logic [REG_ADDR_W-1:0]   rd;
        logic [31:0]             result;
    } stage_t;

    // retire report
    typedef struct packed {
        logic [REG_ADDR_W-1:0]   rd;
        logic [31:0]             value;
    } retire_t;

endpackage

`default_nettype wire

// File: hdl/alu_pipe_top.sv
`timescale 1ns/100ps
`default_nettype none

module alu_pipe_top #(
    parameter int XLEN = 32
) (
    input  wire                                   clk,
    input  wire                                   rst_n,
    input  wire                                   in_valid,
    input  wire  alu_pipe_pkg::instr_t            in_instr,
    output logic                                  retire_valid,
    output alu_pipe_pkg::retire_t                 retire
);

    // D stage
    logic                                  d_valid;
    alu_pipe_pkg::instr_t                  d_instr;
    logic [alu_pipe_pkg::REG_ADDR_W-1:0]   rf_addr1;
    logic [alu_pipe_pkg::REG_ADDR_W-1:0]   rf_addr2;
    logic [XLEN-1:0]                       rf_data1;
    logic [XLEN-1:0]                       rf_data2;
    // hazard paths
    logic [alu_pipe_pkg::REG_ADDR_W-1:0]   e_rs1;
    logic [alu_pipe_pkg::REG_ADDR_W-1:0]   e_rs2;
    alu_pipe_pkg::fwd_sel_e                fwd1;
    alu_pipe_pkg::fwd_sel_e                fwd2;
    logic                                  branch_taken;
    logic                                  flush_d;
    logic                                  flush_e;
    // M and W
    alu_pipe_pkg::stage_t                  m_stage;
    alu_pipe_pkg::stage_t                  w_stage;
    // register-file write
    logic                                  wr_en;
    logic [alu_pipe_pkg::REG_ADDR_W-1:0]   wr_addr;
    logic [XLEN-1:0]                       wr_data;

    reg_file #(.XLEN(XLEN)) i_reg_file (
        .clk, .rst_n,
        .rd_addr1(rf_addr1), .rd_addr2(rf_addr2),
        .rd_data1(rf_data1), .rd_data2(rf_data2),
        .wr_en, .wr_addr, .wr_data
    );

    decode_stage #(.XLEN(XLEN)) i_decode (
        .clk, .rst_n, .in_valid, .in_instr, .flush_d,
        .d_valid, .d_instr, .rf_addr1, .rf_addr2
    );

    hazard_control i_hazard (
        .e_rs1, .e_rs2,
        .m_rd(m_stage.rd), .m_wr(m_stage.wr),
        .w_rd(w_stage.rd), .w_wr(w_stage.wr),
        .branch_taken, .fwd1, .fwd2, .flush_d, .flush_e
    );

    // W result reaches execute as the register-file write data
    execute_stage #(.XLEN(XLEN)) i_execute (
        .clk, .rst_n, .d_valid, .d_instr, .rf_data1, .rf_data2,
        .flush_e, .fwd1, .fwd2, .w_result(wr_data),
        .e_rs1, .e_rs2, .branch_taken, .m_stage
    );

    retire_stage #(.XLEN(XLEN)) i_retire (
        .clk, .rst_n, .m_stage, .w_stage,
        .wr_en, .wr_addr, .wr_data, .retire_valid, .retire
    );

endmodule

`default_nettype wire

// File: hdl/decode_stage.sv
`timescale 1ns/100ps
`default_nettype none

module decode_stage #(
    parameter int XLEN = 32
) (
    input  wire                                   clk,
    input  wire                                   rst_n,
    // incoming instruction strobe
    input  wire                                   in_valid,
    input  wire  alu_pipe_pkg::instr_t            in_instr,
    // taken branch in execute
    input  wire                                   flush_d,
    // D stage
    output logic                                  d_valid,
    output alu_pipe_pkg::instr_t                  d_instr,
    // source register addresses to the register file
    output logic [alu_pipe_pkg::REG_ADDR_W-1:0]   rf_addr1,
    output logic [alu_pipe_pkg::REG_ADDR_W-1:0]   rf_addr2
);

    // immediate must fit in the datapath for sign extension
    if (XLEN < alu_pipe_pkg::IMM_W) begin : g_width_check
        $error("decode_stage: XLEN narrower than the immediate field");
    end

    // valid bit
    // squashed when a branch resolves taken in E
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            d_valid <= 1'b0;
        end else begin
            d_valid <= in_valid && !flush_d;
        end
    end

    // instruction word, held across input gaps
    always_ff @(posedge clk) begin
        if (in_valid) begin
            d_instr <= in_instr;
        end
    end

    // register read happens in D
    // distance-3 producer is in W and writes through this cycle
    assign rf_addr1 = d_instr.rs1;
    assign rf_addr2 = d_instr.rs2;

endmodule

`default_nettype wire

// File: hdl/execute_stage.sv
`timescale 1ns/100ps
`default_nettype none

module execute_stage #(
    parameter int XLEN = 32
) (
    input  wire                                   clk,
    input  wire                                   rst_n,
    // D stage and its register-file operands
    input  wire                                   d_valid,
    input  wire  alu_pipe_pkg::instr_t            d_instr,
    input  wire  [XLEN-1:0]                       rf_data1,
    input  wire  [XLEN-1:0]                       rf_data2,
    // hazard control
    input  wire                                   flush_e,
    input  wire  alu_pipe_pkg::fwd_sel_e          fwd1,
    input  wire  alu_pipe_pkg::fwd_sel_e          fwd2,
    // W result for forwarding
    input  wire  [XLEN-1:0]                       w_result,
    // E sources to hazard control
    output logic [alu_pipe_pkg::REG_ADDR_W-1:0]   e_rs1,
    output logic [alu_pipe_pkg::REG_ADDR_W-1:0]   e_rs2,
    output logic                                  branch_taken,
    // memory-position stage
    output alu_pipe_pkg::stage_t                  m_stage
);

    logic                   e_valid;
    alu_pipe_pkg::instr_t   e_instr;
    logic [XLEN-1:0]        e_data1;
    logic [XLEN-1:0]        e_data2;
    logic [XLEN-1:0]        op1;
    logic [XLEN-1:0]        op2;
    logic [XLEN-1:0]        imm_ext;
    logic [XLEN-1:0]        alu_result;
    logic                   is_alu;
    alu_pipe_pkg::stage_t   m_next;

    // E valid bit, squashed by a taken branch
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            e_valid <= 1'b0;
        end else begin
            e_valid <= d_valid && !flush_e;
        end
    end

    // E payload
    always_ff @(posedge clk) begin
        e_instr <= d_instr;
        e_data1 <= rf_data1;
        e_data2 <= rf_data2;
    end

    assign e_rs1 = e_instr.rs1;
    assign e_rs2 = e_instr.rs2;

    // forwarding muxes
    // M holds the distance-1 producer, W the distance-2 one
    always_comb begin
        case (fwd1)
            alu_pipe_pkg::FWD_MEM: op1 = m_stage.result;
            alu_pipe_pkg::FWD_WB:  op1 = w_result;
            default:               op1 = e_data1;
        endcase
        case (fwd2)
            alu_pipe_pkg::FWD_MEM: op2 = m_stage.result;
            alu_pipe_pkg::FWD_WB:  op2 = w_result;
            default:               op2 = e_data2;
        endcase
    end

    assign imm_ext = XLEN'($signed(e_instr.imm));

    // alu
    always_comb begin
        case (e_instr.opcode)
            alu_pipe_pkg::OP_ADD:  alu_result = op1 + op2;
            alu_pipe_pkg::OP_SUB:  alu_result = op1 - op2;
            alu_pipe_pkg::OP_AND:  alu_result = op1 & op2;
            alu_pipe_pkg::OP_OR:   alu_result = op1 | op2;
            alu_pipe_pkg::OP_XOR:  alu_result = op1 ^ op2;
            alu_pipe_pkg::OP_ADDI: alu_result = op1 + imm_ext;
            default:               alu_result = '0;
        endcase
    end

    // nop and beq produce nothing to write
    assign is_alu = !(e_instr.opcode inside {alu_pipe_pkg::OP_NOP, alu_pipe_pkg::OP_BEQ});

    // compare on forwarded operands
    assign branch_taken = e_valid && e_instr.opcode == alu_pipe_pkg::OP_BEQ && op1 == op2;

    always_comb begin
        m_next.valid  = e_valid;
        m_next.wr     = e_valid && is_alu && e_instr.rd != '0;
        m_next.rd     = e_instr.rd;
        m_next.result = alu_result;
    end

    // M register, only the control bits are reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            m_stage.valid <= 1'b0;
            m_stage.wr    <= 1'b0;
        end else begin
            m_stage <= m_next;
        end
    end

endmodule

`default_nettype wire

// File: hdl/hazard_control.sv
`timescale 1ns/100ps
`default_nettype none

module hazard_control (
    // sources of the instruction in E
    input  wire  [alu_pipe_pkg::REG_ADDR_W-1:0]   e_rs1,
    input  wire  [alu_pipe_pkg::REG_ADDR_W-1:0]   e_rs2,
    // pending writes in M and W
    input  wire  [alu_pipe_pkg::REG_ADDR_W-1:0]   m_rd,
    input  wire                                   m_wr,
    input  wire  [alu_pipe_pkg::REG_ADDR_W-1:0]   w_rd,
    input  wire                                   w_wr,
    // branch compare from execute
    input  wire                                   branch_taken,
    // operand selects for execute
    output alu_pipe_pkg::fwd_sel_e                fwd1,
    output alu_pipe_pkg::fwd_sel_e                fwd2,
    // squash of the two younger stages
    output logic                                  flush_d,
    output logic                                  flush_e
);

    // M is younger than W so it wins on a shared rd
    // r0 reads are zero, never forwarded
    function automatic alu_pipe_pkg::fwd_sel_e pick_src(
        input logic [alu_pipe_pkg::REG_ADDR_W-1:0] rs,
        input logic                                mem_wr,
        input logic [alu_pipe_pkg::REG_ADDR_W-1:0] mem_rd,
        input logic                                wb_wr,
        input logic [alu_pipe_pkg::REG_ADDR_W-1:0] wb_rd
    );
        if (rs == '0)
            return alu_pipe_pkg::FWD_NONE;
        else if (mem_wr && mem_rd == rs)
            return alu_pipe_pkg::FWD_MEM;
        else if (wb_wr && wb_rd == rs)
            return alu_pipe_pkg::FWD_WB;
        else
            return alu_pipe_pkg::FWD_NONE;
    endfunction

    assign fwd1 = pick_src(e_rs1, m_wr, m_rd, w_wr, w_rd);
    assign fwd2 = pick_src(e_rs2, m_wr, m_rd, w_wr, w_rd);

    // branch resolves in E
    // D content and the next accepted word are both wrong-path
    assign flush_d = branch_taken;
    assign flush_e = branch_taken;

endmodule

`default_nettype wire

// File: hdl/reg_file.sv
`timescale 1ns/100ps
`default_nettype none

module reg_file #(
    parameter int XLEN = 32
) (
    input  wire                                   clk,
    input  wire                                   rst_n,
    input  wire  [alu_pipe_pkg::REG_ADDR_W-1:0]   rd_addr1,
    input  wire  [alu_pipe_pkg::REG_ADDR_W-1:0]   rd_addr2,
    output logic [XLEN-1:0]                       rd_data1,
    output logic [XLEN-1:0]                       rd_data2,
    input  wire                                   wr_en,
    input  wire  [alu_pipe_pkg::REG_ADDR_W-1:0]   wr_addr,
    input  wire  [XLEN-1:0]                       wr_data
);

    logic [XLEN-1:0] regs [alu_pipe_pkg::NUM_REGS];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < alu_pipe_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_addr != '0) begin
            // r0 never stored
            regs[wr_addr] <= wr_data;
        end
    end

    // r0 reads zero
    // a same-cycle write wins over the array
    assign rd_data1 = (rd_addr1 == '0) ? '0 :
                      (wr_en && wr_addr == rd_addr1) ? wr_data : regs[rd_addr1];
    assign rd_data2 = (rd_addr2 == '0) ? '0 :
                      (wr_en && wr_addr == rd_addr2) ? wr_data : regs[rd_addr2];

endmodule

`default_nettype wire

// File: hdl/retire_stage.sv
`timescale 1ns/100ps
`default_nettype none

module retire_stage #(
    parameter int XLEN = 32
) (
    input  wire                                   clk,
    input  wire                                   rst_n,
    input  wire  alu_pipe_pkg::stage_t            m_stage,
    // W stage, also read back for forwarding
    output alu_pipe_pkg::stage_t                  w_stage,
    // register-file write port
    output logic                                  wr_en,
    output logic [alu_pipe_pkg::REG_ADDR_W-1:0]   wr_addr,
    output logic [XLEN-1:0]                       wr_data,
    // retire report
    output logic                                  retire_valid,
    output alu_pipe_pkg::retire_t                 retire
);

    // W register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            w_stage.valid <= 1'b0;
            w_stage.wr    <= 1'b0;
        end else begin
            w_stage <= m_stage;
        end
    end

    // write lands on the edge that leaves W
    assign wr_en   = w_stage.wr;
    assign wr_addr = w_stage.rd;
    assign wr_data = w_stage.result;

    // only register writers with rd != 0 retire
    assign retire_valid = w_stage.valid && w_stage.wr;
    assign retire.rd    = w_stage.rd;
    assign retire.value = w_stage.result;

endmodule

`default_nettype wire

// File: testbench/alu_pipe_props.sv
`timescale 1ns/100ps
`default_nettype none

module alu_pipe_props (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire                       retire_valid,
    input  wire  alu_pipe_pkg::retire_t retire,
    input  wire                       flush_e,
    input  wire                       e_valid
);

    // a retiring instruction always names a real register
    rd_nonzero: assert property (
        @(posedge clk) disable iff (!rst_n)
        retire_valid |-> retire.rd != '0
    ) else $error("retire reported for register 0");

    // squashed slot stays empty in E
    flush_clears_e: assert property (
        @(posedge clk) disable iff (!rst_n)
        flush_e |=> !e_valid
    ) else $error("execute stage valid in the cycle after a flush");

    // nothing leaves W while reset is held
    quiet_in_reset: assert property (
        @(posedge clk)
        !rst_n |=> !retire_valid
    ) else $error("retire_valid high during reset");

endmodule

// E valid bit lives inside the execute stage
bind alu_pipe_top alu_pipe_props i_props (
    .clk,
    .rst_n,
    .retire_valid,
    .retire,
    .flush_e,
    .e_valid(i_execute.e_valid)
);

`default_nettype wire

// File: testbench/alu_pipe_tb.sv
`timescale 1ns/100ps
`default_nettype none

module alu_pipe_tb;

    localparam int CLK_PERIOD = 20;
    localparam int RESET_CYCLES = 16;
    // each directed test stays under 40 cycles with its drain
    localparam int DIRECTED_CYCLES = 5 * 40;
    // one instruction plus up to four idle cycles each
    localparam int RANDOM_CYCLES = 200 * 5 + 10;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES + 50;

    typedef struct packed {
        int          due;
        logic [4:0]  rd;
        logic [31:0] value;
    } expect_t;

    logic                  clk = 1'b0;
    logic                  rst_n;
    logic                  in_valid;
    alu_pipe_pkg::instr_t  in_instr;
    logic                  retire_valid;
    alu_pipe_pkg::retire_t retire;

    integer      seed = 32'h3e4c_6a82;
    int          edges = 0;
    int          errors = 0;
    int          err_mark = 0;
    int          n_pass = 0;
    int          n_fail = 0;
    // last accept edge killed by a taken branch
    int          squash_last = 0;
    logic        flush_seen = 1'b0;
    logic [31:0] model_regs [32];
    expect_t     exp_q [$];

    alu_pipe_top #(.XLEN(32)) i_dut (
        .clk, .rst_n, .in_valid, .in_instr, .retire_valid, .retire
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) edges <= edges + 1;

    // outputs checked mid-cycle
    // model fed with the word of the next edge
    always @(negedge clk) begin : check_and_model
        expect_t              exp;
        alu_pipe_pkg::instr_t ins;
        logic [31:0]          a;
        logic [31:0]          b;
        logic [31:0]          res;
        int                   k;
        if (!rst_n) begin
            assert (!retire_valid) else begin
                $display("retire_valid high while reset is held at %0t", $time);
                errors++;
            end
        end else begin
            assert (!(flush_seen && i_dut.i_execute.e_valid)) else begin
                $display("execute stage still valid after a flush at %0t", $time);
                errors++;
            end
            if (retire_valid) begin
                assert (exp_q.size() != 0) else begin
                    $display("unexpected retire of r%0d at %0t", retire.rd, $time);
                    errors++;
                end
                if (exp_q.size() != 0) begin
                    exp = exp_q.pop_front();
                    assert (exp.due == edges) else begin
                        $display("r%0d retired after edge %0d instead of edge %0d at %0t",
                                 exp.rd, edges, exp.due, $time);
                        errors++;
                    end
                    assert (retire.rd == exp.rd) else begin
                        $display("[ERROR] %0t retire.rd expected %0d got %0d",
                                 $time, exp.rd, retire.rd);
                        errors++;
                    end
                    assert (retire.value == exp.value) else begin
                        $display("[ERROR] %0t retire.value expected %h got %h",
                                 $time, exp.value, retire.value);
                        errors++;
                    end
                end
            end else if (exp_q.size() != 0) begin
                assert (exp_q[0].due > edges) else begin
                    $display("r%0d never retired, due after edge %0d",
                             exp_q[0].rd, exp_q[0].due);
                    exp = exp_q.pop_front();
                    errors++;
                end
            end
            // reference model, in program order
            k = edges + 1;
            if (in_valid && k > squash_last) begin
                ins = in_instr;
                a = model_regs[ins.rs1];
                b = model_regs[ins.rs2];
                case (ins.opcode)
                    alu_pipe_pkg::OP_ADD:  res = a + b;
                    alu_pipe_pkg::OP_SUB:  res = a - b;
                    alu_pipe_pkg::OP_AND:  res = a & b;
                    alu_pipe_pkg::OP_OR:   res = a | b;
                    alu_pipe_pkg::OP_XOR:  res = a ^ b;
                    alu_pipe_pkg::OP_ADDI: res = a + {{16{ins.imm[15]}}, ins.imm};
                    default:               res = '0;
                endcase
                if (ins.opcode == alu_pipe_pkg::OP_BEQ) begin
                    // taken branch kills the next two accept edges
                    if (a == b)
                        squash_last = k + 2;
                end else if (ins.opcode != alu_pipe_pkg::OP_NOP && ins.rd != 0) begin
                    model_regs[ins.rd] = res;
                    exp.due = k + 3;
                    exp.rd = ins.rd;
                    exp.value = res;
                    exp_q.push_back(exp);
                end
            end
        end
        flush_seen = rst_n && i_dut.flush_e;
    end

    function automatic alu_pipe_pkg::instr_t encode(
        input alu_pipe_pkg::opcode_e op,
        input int rd,
        input int rs1,
        input int rs2,
        input int imm
    );
        alu_pipe_pkg::instr_t i;
        i.opcode = op;
        i.rd = 5'(rd);
        i.rs1 = 5'(rs1);
        i.rs2 = 5'(rs2);
        i.imm = 16'(imm);
        return i;
    endfunction

    task automatic send(input alu_pipe_pkg::instr_t instr);
        @(posedge clk);
        in_valid <= 1'b1;
        in_instr <= instr;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            in_valid <= 1'b0;
        end
    endtask

    // pipeline depth of idle, then wait for every expected retire
    task automatic finish_test(input string name);
        idle(4);
        while (exp_q.size() != 0) @(negedge clk);
        if (errors == err_mark) begin
            n_pass++;
            $display("test %s: pass", name);
        end else begin
            n_fail++;
            $display("test %s: fail, %0d errors", name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    task automatic random_mix();
        logic [31:0]          r;
        logic [31:0]          r_imm;
        alu_pipe_pkg::instr_t i;
        for (int n = 0; n < 200; n++) begin
            r = $random(seed);
            r_imm = $random(seed);
            // small register range keeps hazards frequent
            i.opcode = alu_pipe_pkg::opcode_e'(r[2:0]);
            i.rd = {2'b00, r[5:3]};
            i.rs1 = {2'b00, r[8:6]};
            i.rs2 = {2'b00, r[11:9]};
            i.imm = r_imm[15:0];
            send(i);
            if (r[13:12] == 2'b00)
                idle(1 + r[15:14]);
        end
    endtask

    initial begin : main
        in_valid = 1'b0;
        in_instr = '0;
        rst_n = 1'b0;
        for (int r = 0; r < 32; r++)
            model_regs[r] = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;

        // every opcode, sources at distance four or more
        send(encode(alu_pipe_pkg::OP_ADDI, 1, 0, 0, 16'h1234));
        send(encode(alu_pipe_pkg::OP_ADDI, 2, 0, 0, -3));
        send(encode(alu_pipe_pkg::OP_ADDI, 3, 0, 0, 16'h00f0));
        send(encode(alu_pipe_pkg::OP_NOP, 0, 0, 0, 0));
        send(encode(alu_pipe_pkg::OP_NOP, 0, 0, 0, 0));
        send(encode(alu_pipe_pkg::OP_NOP, 0, 0, 0, 0));
        send(encode(alu_pipe_pkg::OP_ADD, 4, 1, 2, 0));
        send(encode(alu_pipe_pkg::OP_SUB, 5, 1, 2, 0));
        send(encode(alu_pipe_pkg::OP_AND, 6, 1, 3, 0));
        send(encode(alu_pipe_pkg::OP_OR, 7, 1, 3, 0));
        send(encode(alu_pipe_pkg::OP_XOR, 8, 2, 3, 0));
        finish_test("independent_ops");

        // distance 1 and 2, then M and W both holding r13
        send(encode(alu_pipe_pkg::OP_ADDI, 10, 0, 0, 5));
        send(encode(alu_pipe_pkg::OP_ADD, 11, 10, 10, 0));
        send(encode(alu_pipe_pkg::OP_SUB, 12, 10, 11, 0));
        send(encode(alu_pipe_pkg::OP_ADDI, 13, 0, 0, 1));
        send(encode(alu_pipe_pkg::OP_ADDI, 13, 0, 0, 2));
        send(encode(alu_pipe_pkg::OP_ADD, 14, 13, 13, 0));
        send(encode(alu_pipe_pkg::OP_XOR, 15, 13, 14, 0));
        finish_test("forwarding");

        // distance 3 through nops, then through input gaps
        send(encode(alu_pipe_pkg::OP_ADDI, 16, 0, 0, 77));
        send(encode(alu_pipe_pkg::OP_NOP, 0, 0, 0, 0));
        send(encode(alu_pipe_pkg::OP_NOP, 0, 0, 0, 0));
        send(encode(alu_pipe_pkg::OP_ADD, 17, 16, 0, 0));
        send(encode(alu_pipe_pkg::OP_ADDI, 18, 0, 0, 9));
        idle(2);
        send(encode(alu_pipe_pkg::OP_OR, 19, 18, 16, 0));
        finish_test("write_through");

        // r0 writes are dropped and r0 reads stay zero
        send(encode(alu_pipe_pkg::OP_ADDI, 0, 0, 0, 55));
        send(encode(alu_pipe_pkg::OP_ADD, 20, 0, 0, 0));
        send(encode(alu_pipe_pkg::OP_ADDI, 0, 1, 0, 1));
        send(encode(alu_pipe_pkg::OP_NOP, 0, 0, 0, 0));
        send(encode(alu_pipe_pkg::OP_ADD, 21, 0, 1, 0));
        finish_test("register_zero");

        // taken, not taken, then taken with a gap in the shadow
        send(encode(alu_pipe_pkg::OP_ADDI, 22, 0, 0, 9));
        send(encode(alu_pipe_pkg::OP_ADDI, 23, 0, 0, 9));
        send(encode(alu_pipe_pkg::OP_ADDI, 24, 0, 0, 8));
        send(encode(alu_pipe_pkg::OP_BEQ, 0, 22, 23, 0));
        send(encode(alu_pipe_pkg::OP_ADDI, 25, 0, 0, 1));
        send(encode(alu_pipe_pkg::OP_ADDI, 26, 0, 0, 2));
        send(encode(alu_pipe_pkg::OP_ADDI, 27, 0, 0, 3));
        send(encode(alu_pipe_pkg::OP_BEQ, 0, 22, 24, 0));
        send(encode(alu_pipe_pkg::OP_ADDI, 28, 0, 0, 4));
        send(encode(alu_pipe_pkg::OP_ADDI, 29, 0, 0, 5));
        send(encode(alu_pipe_pkg::OP_BEQ, 0, 0, 0, 0));
        idle(1);
        send(encode(alu_pipe_pkg::OP_ADDI, 30, 0, 0, 6));
        send(encode(alu_pipe_pkg::OP_ADDI, 31, 0, 0, 7));
        send(encode(alu_pipe_pkg::OP_ADD, 1, 25, 26, 0));
        finish_test("branch_squash");

        random_mix();
        finish_test("random_mix");

        $display("tests: %0d passed, %0d failed", n_pass, n_fail);
        if (errors == 0 && n_fail == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

    initial begin : watchdog
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("timeout after %0d cycles, the run did not complete", TIMEOUT_CYCLES);
        $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire
